/* wisc_pkg.sv */
package wisc_pkg;

   typedef logic [15:0] word_t;   // Data, address and instruction word
   typedef logic [2:0]  reg_idx_t;

   // Major opcodes in instr[15:11]
   typedef enum logic [4:0] {
      OP_HALT      = 5'b00000,
      OP_NOP       = 5'b00001,
      OP_SIIC      = 5'b00010,
      OP_NOP2      = 5'b00011,
      OP_J         = 5'b00100,
      OP_JR        = 5'b00101,
      OP_JAL       = 5'b00110,
      OP_JALR      = 5'b00111,
      OP_ADDI      = 5'b01000,
      OP_SUBI      = 5'b01001,
      OP_XORI      = 5'b01010,
      OP_ANDNI     = 5'b01011,
      OP_BEQZ      = 5'b01100,
      OP_BNEZ      = 5'b01101,
      OP_BLTZ      = 5'b01110,
      OP_BGEZ      = 5'b01111,
      OP_ST        = 5'b10000,
      OP_LD        = 5'b10001,
      OP_SLBI      = 5'b10010,
      OP_STU       = 5'b10011,
      OP_ROLI      = 5'b10100,
      OP_SLLI      = 5'b10101,
      OP_RORI      = 5'b10110,
      OP_SRLI      = 5'b10111,
      OP_LBI       = 5'b11000,
      OP_BTR       = 5'b11001,
      OP_ALU_SHIFT = 5'b11010,   // ROL, SLL, ROR, SRL by instr[1:0]
      OP_ALU_ARITH = 5'b11011,   // ADD, SUB, XOR, ANDN by instr[1:0]
      OP_SEQ       = 5'b11100,
      OP_SLT       = 5'b11101,
      OP_SLE       = 5'b11110,
      OP_SCO       = 5'b11111
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ROL = 3'b000,
      ALU_SLL = 3'b001,
      ALU_ROR = 3'b010,
      ALU_SRL = 3'b011,
      ALU_ADD = 3'b100,
      ALU_AND = 3'b101,
      ALU_BTR = 3'b110,
      ALU_XOR = 3'b111
   } alu_op_e;

   typedef enum logic [1:0] {
      IMM_ZEXT5  = 2'b00,   // zext(instr[4:0])
      IMM_SEXT5  = 2'b01,   // sext(instr[4:0])
      IMM_SEXT8  = 2'b10,   // sext(instr[7:0])
      IMM_SEXT11 = 2'b11    // sext(instr[10:0])
   } sext_op_e;

   typedef enum logic [2:0] {
      WB_ALU     = 3'b000,
      WB_MEM     = 3'b001,
      WB_PC_LINK = 3'b010,
      WB_SET     = 3'b011,
      WB_IMM     = 3'b100,
      WB_SLBI    = 3'b101
   } wr_sel_e;

   typedef enum logic [1:0] {
      DST_RD = 2'b00,   // instr[4:2]
      DST_RT = 2'b01,   // instr[7:5]
      DST_RS = 2'b10,   // instr[10:8]
      DST_R7 = 2'b11
   } wr_reg_sel_e;

   typedef enum logic [1:0] {
      SET_CARRY = 2'b00,
      SET_EQ    = 2'b01,
      SET_LT    = 2'b10,
      SET_LE    = 2'b11
   } set_sel_e;

   typedef enum logic [1:0] {
      BR_EQZ = 2'b00,
      BR_NEZ = 2'b01,
      BR_LTZ = 2'b10,
      BR_GEZ = 2'b11
   } br_cnd_e;

   typedef struct packed {
      br_cnd_e     br_cnd;
      set_sel_e    set_sel;
      logic        wr_en;           // Register write back
      logic        has_rt;          // Rt is a source operand
      logic        mem_wr_en;
      logic        mem_en;
      wr_sel_e     wr_sel;
      wr_reg_sel_e wr_reg_sel;
      logic        oprnd_sel;       // Immediate as ALU operand B
      logic        jmp_reg_instr;
      logic        jmp_instr;
      logic        br_instr;
      sext_op_e    sext_op;
      alu_op_e     alu_op;
      logic        alu_inv_a;
      logic        alu_inv_b;
      logic        alu_cin;
      logic        alu_sign;        // Signed compare
      logic        pc_en;           // Low stops the PC
      logic        err;             // Illegal instruction
   } ctrl_t;

endpackage

/* control.sv */
`timescale 1ns/1ns

module control (
   input  wisc_pkg::word_t instr,
   output wisc_pkg::ctrl_t ctrl
);

   import wisc_pkg::*;

   opcode_e opcode;

   assign opcode = opcode_e'(instr[15:11]);

   always_comb begin
      ctrl.br_cnd        = BR_EQZ;
      ctrl.set_sel       = SET_CARRY;
      ctrl.wr_en         = 1'b0;
      ctrl.has_rt        = 1'b0;
      ctrl.mem_wr_en     = 1'b0;
      ctrl.mem_en        = 1'b0;
      ctrl.wr_sel        = WB_ALU;
      ctrl.wr_reg_sel    = DST_RD;
      ctrl.oprnd_sel     = 1'b0;
      ctrl.jmp_reg_instr = 1'b0;
      ctrl.jmp_instr     = 1'b0;
      ctrl.br_instr      = 1'b0;
      ctrl.sext_op       = IMM_ZEXT5;
      ctrl.alu_op        = ALU_ROL;
      ctrl.alu_inv_a     = 1'b0;
      ctrl.alu_inv_b     = 1'b0;
      ctrl.alu_cin       = 1'b0;
      ctrl.alu_sign      = 1'b1;
      ctrl.pc_en         = 1'b1;
      ctrl.err           = 1'b0;

      case (opcode)
         OP_HALT: ctrl.pc_en = 1'b0;
         OP_NOP, OP_SIIC, OP_NOP2: begin
            // Only the PC advances
         end
         OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI,
         OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: begin
            ctrl.wr_en      = 1'b1;
            ctrl.wr_reg_sel = DST_RT;
            ctrl.oprnd_sel  = 1'b1;
            case (opcode)
               OP_ADDI: begin
                  ctrl.sext_op = IMM_SEXT5;
                  ctrl.alu_op  = ALU_ADD;
               end
               OP_SUBI: begin                       // Imm - Rs
                  ctrl.sext_op   = IMM_SEXT5;
                  ctrl.alu_op    = ALU_ADD;
                  ctrl.alu_inv_a = 1'b1;
                  ctrl.alu_cin   = 1'b1;
               end
               OP_XORI: ctrl.alu_op = ALU_XOR;
               OP_ANDNI: begin
                  ctrl.alu_op    = ALU_AND;
                  ctrl.alu_inv_b = 1'b1;
               end
               OP_ROLI: ctrl.alu_op = ALU_ROL;
               OP_SLLI: ctrl.alu_op = ALU_SLL;
               OP_RORI: ctrl.alu_op = ALU_ROR;
               default: ctrl.alu_op = ALU_SRL;
            endcase
         end
         OP_ST, OP_LD, OP_STU: begin               // Address is Rs + sext5
            ctrl.mem_en     = 1'b1;
            ctrl.oprnd_sel  = 1'b1;
            ctrl.sext_op    = IMM_SEXT5;
            ctrl.alu_op     = ALU_ADD;
            ctrl.mem_wr_en  = (opcode != OP_LD);
            ctrl.wr_en      = (opcode != OP_ST);
            ctrl.wr_sel     = (opcode == OP_LD) ? WB_MEM : WB_ALU;
            ctrl.wr_reg_sel = (opcode == OP_STU) ? DST_RS : DST_RT;
         end
         OP_BTR: begin
            ctrl.wr_en  = 1'b1;
            ctrl.alu_op = ALU_BTR;
         end
         OP_ALU_ARITH: begin
            ctrl.wr_en     = 1'b1;
            ctrl.has_rt    = 1'b1;
            ctrl.alu_op    = !instr[1] ? ALU_ADD : (!instr[0] ? ALU_XOR : ALU_AND);
            ctrl.alu_inv_a = ~instr[1] & instr[0];  // SUB is Rt - Rs
            ctrl.alu_inv_b = instr[1] & instr[0];   // ANDN
            ctrl.alu_cin   = ~instr[1] & instr[0];
         end
         OP_ALU_SHIFT: begin
            ctrl.wr_en  = 1'b1;
            ctrl.has_rt = 1'b1;
            ctrl.alu_op = alu_op_e'({1'b0, instr[1:0]});
         end
         OP_SEQ, OP_SLT, OP_SLE: begin             // Rs - Rt sets the flags
            ctrl.wr_en     = 1'b1;
            ctrl.has_rt    = 1'b1;
            ctrl.wr_sel    = WB_SET;
            ctrl.alu_op    = ALU_ADD;
            ctrl.alu_inv_b = 1'b1;
            ctrl.alu_cin   = 1'b1;
            ctrl.set_sel   = (opcode == OP_SEQ) ? SET_EQ :
                             (opcode == OP_SLT) ? SET_LT : SET_LE;
         end
         OP_SCO: begin
            ctrl.wr_en    = 1'b1;
            ctrl.has_rt   = 1'b1;
            ctrl.wr_sel   = WB_SET;
            ctrl.set_sel  = SET_CARRY;
            ctrl.alu_sign = 1'b0;
            ctrl.alu_op   = ALU_ADD;
         end
         OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
            ctrl.br_instr = 1'b1;
            ctrl.sext_op  = IMM_SEXT8;
            ctrl.br_cnd   = br_cnd_e'(instr[12:11]); // Low opcode bits pick the test
         end
         OP_LBI, OP_SLBI: begin
            ctrl.wr_en      = 1'b1;
            ctrl.wr_reg_sel = DST_RS;
            ctrl.sext_op    = IMM_SEXT8;
            ctrl.wr_sel     = (opcode == OP_LBI) ? WB_IMM : WB_SLBI;
         end
         OP_J, OP_JAL: begin
            ctrl.jmp_instr = 1'b1;
            ctrl.sext_op   = IMM_SEXT11;
            if (opcode == OP_JAL) begin
               ctrl.wr_en      = 1'b1;
               ctrl.wr_sel     = WB_PC_LINK;
               ctrl.wr_reg_sel = DST_R7;
            end
         end
         OP_JR, OP_JALR: begin                      // Target is Rs + sext8
            ctrl.jmp_instr     = 1'b1;
            ctrl.jmp_reg_instr = 1'b1;
            ctrl.oprnd_sel     = 1'b1;
            ctrl.alu_op        = ALU_ADD;
            ctrl.sext_op       = IMM_SEXT8;
            if (opcode == OP_JALR) begin
               ctrl.wr_en      = 1'b1;
               ctrl.wr_sel     = WB_PC_LINK;
               ctrl.wr_reg_sel = DST_R7;
            end
         end
         default: begin                             // Unknown opcode bits
            ctrl.err   = 1'b1;
            ctrl.pc_en = 1'b0;
         end
      endcase
   end

endmodule

/* reg_file.sv */
`timescale 1ns/1ns

module reg_file (
   input  logic              clk,
   input  logic              rst,
   input  wisc_pkg::reg_idx_t rs_idx,
   input  wisc_pkg::reg_idx_t rt_idx,
   input  wisc_pkg::reg_idx_t wr_idx,
   input  logic              wr_en,
   input  wisc_pkg::word_t   wr_data,
   output wisc_pkg::word_t   rs_data,
   output wisc_pkg::word_t   rt_data
);

   import wisc_pkg::*;

   word_t regs [8];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_idx] <= wr_data;                   // Visible from the next cycle
      end
   end

   assign rs_data = regs[rs_idx];
   assign rt_data = regs[rt_idx];

endmodule

/* alu.sv */
`timescale 1ns/1ns

module alu (
   input  wisc_pkg::word_t   a,
   input  wisc_pkg::word_t   b,
   input  wisc_pkg::alu_op_e op,
   input  logic              inv_a,
   input  logic              inv_b,
   input  logic              cin,
   input  logic              sign,
   output wisc_pkg::word_t   result,
   output logic              zero,
   output logic              carry,
   output logic              lt
);

   import wisc_pkg::*;

   word_t       a_eff;
   word_t       b_eff;
   word_t       sum;
   word_t       rev;
   logic [31:0] rot_l;
   logic [31:0] rot_r;
   logic        ovf;

   assign a_eff = inv_a ? ~a : a;
   assign b_eff = inv_b ? ~b : b;

   assign {carry, sum} = {1'b0, a_eff} + {1'b0, b_eff} + {16'b0, cin};

   // Two's complement overflow of the add
   assign ovf = (a_eff[15] == b_eff[15]) && (sum[15] != a_eff[15]);

   assign rot_l = {a_eff, a_eff} << b_eff[3:0];
   assign rot_r = {a_eff, a_eff} >> b_eff[3:0];

   always_comb begin
      for (int i = 0; i < 16; i++) begin
         rev[i] = a_eff[15 - i];
      end
   end

   always_comb begin
      case (op)
         ALU_ROL: result = rot_l[31:16];
         ALU_SLL: result = a_eff << b_eff[3:0];
         ALU_ROR: result = rot_r[15:0];
         ALU_SRL: result = a_eff >> b_eff[3:0];
         ALU_ADD: result = sum;
         ALU_AND: result = a_eff & b_eff;
         ALU_BTR: result = rev;
         ALU_XOR: result = a_eff ^ b_eff;
         default: result = sum;
      endcase
   end

   assign zero = (result == '0);
   assign lt   = sign ? (sum[15] ^ ovf) : ~carry;   // Valid for a + ~b + 1

endmodule

/* pc_unit.sv */
`timescale 1ns/1ns

module pc_unit (
   input  logic            clk,
   input  logic            rst,
   input  wisc_pkg::ctrl_t ctrl,
   input  wisc_pkg::word_t instr,
   input  wisc_pkg::word_t rs_data,
   input  wisc_pkg::word_t alu_result,
   output wisc_pkg::word_t pc,
   output wisc_pkg::word_t pc_plus2
);

   import wisc_pkg::*;

   word_t pc_next;
   word_t br_off;
   word_t jmp_off;
   logic  br_taken;

   assign pc_plus2 = pc + 16'd2;
   assign br_off   = {{8{instr[7]}}, instr[7:0]};
   assign jmp_off  = {{5{instr[10]}}, instr[10:0]};

   always_comb begin
      case (ctrl.br_cnd)
         BR_EQZ:  br_taken = (rs_data == '0);
         BR_NEZ:  br_taken = (rs_data != '0);
         BR_LTZ:  br_taken = rs_data[15];
         default: br_taken = ~rs_data[15];
      endcase
   end

   always_comb begin
      if (ctrl.jmp_reg_instr)
         pc_next = alu_result;                      // Rs + sext8
      else if (ctrl.jmp_instr)
         pc_next = pc_plus2 + jmp_off;
      else if (ctrl.br_instr && br_taken)
         pc_next = pc_plus2 + br_off;
      else
         pc_next = pc_plus2;
   end

   always_ff @(posedge clk) begin
      if (rst)
         pc <= '0;
      else if (ctrl.pc_en)
         pc <= pc_next;                             // Holds on HALT or error
   end

endmodule

/* instr_mem.sv */
`timescale 1ns/1ns

module instr_mem #(
   parameter int IMEM_AW = 8
) (
   input  logic               clk,
   input  logic               we,
   input  logic [IMEM_AW-1:0] waddr,
   input  logic [IMEM_AW-1:0] raddr,
   input  wisc_pkg::word_t    wdata,
   output wisc_pkg::word_t    rdata
);

   import wisc_pkg::*;

   word_t mem [2**IMEM_AW];

   always_ff @(posedge clk) begin
      if (we)
         mem[waddr] <= wdata;                       // Program load
   end

   assign rdata = mem[raddr];

endmodule

/* data_mem.sv */
`timescale 1ns/1ns

module data_mem #(
   parameter int DMEM_AW = 8
) (
   input  logic            clk,
   input  logic            en,
   input  logic            wr_en,
   input  wisc_pkg::word_t addr,
   input  wisc_pkg::word_t wdata,
   output wisc_pkg::word_t rdata
);

   import wisc_pkg::*;

   word_t              mem [2**DMEM_AW];
   logic [DMEM_AW-1:0] idx;

   assign idx = addr[DMEM_AW:1];                    // Byte address to word index

   always_ff @(posedge clk) begin
      if (en && wr_en)
         mem[idx] <= wdata;
   end

   assign rdata = mem[idx];

endmodule

/* cpu_top.sv */
`timescale 1ns/1ns

module cpu_top #(
   parameter int IMEM_AW = 8,
   parameter int DMEM_AW = 8
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               prog_we,
   input  logic [IMEM_AW-1:0] prog_addr,
   input  wisc_pkg::word_t    prog_data,
   output logic               halted,
   output logic               err,
   output logic               wb_en,
   output wisc_pkg::reg_idx_t wb_reg,
   output wisc_pkg::word_t    wb_data
);

   import wisc_pkg::*;

   word_t    instr;
   ctrl_t    ctrl;
   word_t    pc;
   word_t    pc_plus2;
   word_t    rs_data;
   word_t    rt_data;
   word_t    imm;
   word_t    alu_b;
   word_t    alu_result;
   word_t    mem_rdata;
   word_t    set_result;
   logic     alu_zero;
   logic     alu_carry;
   logic     alu_lt;

   always_comb begin
      case (ctrl.sext_op)
         IMM_ZEXT5:  imm = {11'b0, instr[4:0]};
         IMM_SEXT5:  imm = {{11{instr[4]}}, instr[4:0]};
         IMM_SEXT8:  imm = {{8{instr[7]}}, instr[7:0]};
         default:    imm = {{5{instr[10]}}, instr[10:0]};
      endcase
   end

   assign alu_b = ctrl.oprnd_sel ? imm : rt_data;

   always_comb begin
      case (ctrl.set_sel)
         SET_CARRY: set_result = {15'b0, alu_carry};
         SET_EQ:    set_result = {15'b0, alu_zero};
         SET_LT:    set_result = {15'b0, alu_lt};
         default:   set_result = {15'b0, alu_lt | alu_zero};
      endcase
   end

   always_comb begin
      case (ctrl.wr_sel)
         WB_MEM:     wb_data = mem_rdata;
         WB_PC_LINK: wb_data = pc_plus2;
         WB_SET:     wb_data = set_result;
         WB_IMM:     wb_data = imm;
         WB_SLBI:    wb_data = {rs_data[7:0], instr[7:0]};
         default:    wb_data = alu_result;
      endcase
   end

   always_comb begin
      case (ctrl.wr_reg_sel)
         DST_RD:  wb_reg = instr[4:2];
         DST_RT:  wb_reg = instr[7:5];
         DST_RS:  wb_reg = instr[10:8];
         default: wb_reg = 3'd7;
      endcase
   end

   assign wb_en  = ctrl.wr_en & ~rst;               // No trace while held in reset
   assign halted = ~ctrl.pc_en;
   assign err    = ctrl.err;

   instr_mem #(.IMEM_AW(IMEM_AW)) i_imem (
      .clk(clk), .we(prog_we), .waddr(prog_addr), .raddr(pc[IMEM_AW:1]),
      .wdata(prog_data), .rdata(instr)
   );

   control i_ctrl (.instr(instr), .ctrl(ctrl));

   reg_file i_rf (
      .clk(clk), .rst(rst), .rs_idx(instr[10:8]), .rt_idx(instr[7:5]), .wr_idx(wb_reg),
      .wr_en(ctrl.wr_en), .wr_data(wb_data), .rs_data(rs_data), .rt_data(rt_data)
   );

   alu i_alu (
      .a(rs_data), .b(alu_b), .op(ctrl.alu_op), .inv_a(ctrl.alu_inv_a),
      .inv_b(ctrl.alu_inv_b), .cin(ctrl.alu_cin), .sign(ctrl.alu_sign),
      .result(alu_result), .zero(alu_zero), .carry(alu_carry), .lt(alu_lt)
   );

   pc_unit i_pc (
      .clk(clk), .rst(rst), .ctrl(ctrl), .instr(instr), .rs_data(rs_data),
      .alu_result(alu_result), .pc(pc), .pc_plus2(pc_plus2)
   );

   data_mem #(.DMEM_AW(DMEM_AW)) i_dmem (
      .clk(clk), .en(ctrl.mem_en), .wr_en(ctrl.mem_wr_en), .addr(alu_result),
      .wdata(rt_data), .rdata(mem_rdata)
   );

endmodule

/* tb_cpu.sv */
`timescale 1ns/1ns

module tb_cpu;

   import wisc_pkg::*;

   typedef struct packed {
      reg_idx_t idx;
      word_t    data;
   } wb_entry_t;

   localparam int TIMEOUT_CYCLES   = 500;
   localparam int POST_HALT_CYCLES = 4;

   logic      clk;
   logic      rst;
   logic      prog_we;
   logic [7:0] prog_addr;
   word_t     prog_data;
   logic      halted;
   logic      err;
   logic      wb_en;
   reg_idx_t  wb_reg;
   word_t     wb_data;

   word_t     prog [$];           // Program under construction
   wb_entry_t exp_q [$];          // Predicted register writes in order
   word_t     model_regs [8];
   word_t     model_mem [256];    // Persists across programs like the DUT memory

   cpu_top #(.IMEM_AW(8), .DMEM_AW(8)) i_dut (
      .clk(clk), .rst(rst), .prog_we(prog_we), .prog_addr(prog_addr),
      .prog_data(prog_data), .halted(halted), .err(err), .wb_en(wb_en),
      .wb_reg(wb_reg), .wb_data(wb_data)
   );

   always #20 clk = ~clk;

   task automatic report_mismatch(input string msg);
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic abort_run(input string msg);
      $display("ERROR: %s", msg);
      $display("Simulation failed");
      $fatal(1);
   endtask

   function automatic word_t enc_imm5(opcode_e op, reg_idx_t rs, reg_idx_t rd, logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic word_t enc_reg(opcode_e op, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd,
                                     logic [1:0] fn);
      return {op, rs, rt, rd, fn};
   endfunction

   function automatic word_t enc_imm8(opcode_e op, reg_idx_t rs, logic [7:0] imm);
      return {op, rs, imm};
   endfunction

   function automatic word_t enc_imm11(opcode_e op, logic [10:0] imm);
      return {op, imm};
   endfunction

   function automatic word_t rot_left(word_t x, logic [3:0] n);
      int i;
      for (i = 0; i < n; i++) begin
         x = {x[14:0], x[15]};
      end
      return x;
   endfunction

   function automatic word_t rot_right(word_t x, logic [3:0] n);
      int i;
      for (i = 0; i < n; i++) begin
         x = {x[0], x[15:1]};
      end
      return x;
   endfunction

   function automatic word_t bit_rev(word_t x);
      word_t r;
      int    i;
      r = '0;
      for (i = 0; i < 16; i++) begin
         r = {r[14:0], x[i]};                        // Bit 0 ends up on top
      end
      return r;
   endfunction

   task automatic load_const(input reg_idx_t r, input word_t v);
      prog.push_back(enc_imm8(OP_LBI, r, v[15:8]));
      prog.push_back(enc_imm8(OP_SLBI, r, v[7:0]));   // Shifts the high byte up
   endtask

   task automatic record_write(input reg_idx_t r, input word_t v);
      wb_entry_t e;
      e.idx  = r;
      e.data = v;
      model_regs[r] = v;
      exp_q.push_back(e);
   endtask

   // Instruction-level ISA model that predicts the trace before the DUT runs
   task automatic predict(output logic exp_err);
      word_t pc;
      word_t w;
      word_t rs;
      word_t rt;
      word_t s5;
      word_t z5;
      word_t s8;
      word_t s11;
      word_t ea;
      word_t nxt;
      word_t r;
      logic  done;
      int    steps;
      int    i;
      pc      = '0;
      exp_err = 1'b0;
      done    = 1'b0;
      steps   = 0;
      for (i = 0; i < 8; i++) begin
         model_regs[i] = '0;
      end
      while (!done) begin
         w = prog[pc[15:1]];
         if ($isunknown(w[15:11])) begin
            exp_err = 1'b1;                            // Undefined opcode stops the core
            done    = 1'b1;
         end else begin
            rs  = model_regs[w[10:8]];
            rt  = model_regs[w[7:5]];
            s5  = {{11{w[4]}}, w[4:0]};
            z5  = {11'b0, w[4:0]};
            s8  = {{8{w[7]}}, w[7:0]};
            s11 = {{5{w[10]}}, w[10:0]};
            ea  = rs + s5;
            nxt = pc + 16'd2;
            case (opcode_e'(w[15:11]))
               OP_HALT:  done = 1'b1;
               OP_ADDI:  record_write(w[7:5], rs + s5);
               OP_SUBI:  record_write(w[7:5], s5 - rs);
               OP_XORI:  record_write(w[7:5], rs ^ z5);
               OP_ANDNI: record_write(w[7:5], rs & ~z5);
               OP_ROLI:  record_write(w[7:5], rot_left(rs, w[3:0]));
               OP_SLLI:  record_write(w[7:5], rs << w[3:0]);
               OP_RORI:  record_write(w[7:5], rot_right(rs, w[3:0]));
               OP_SRLI:  record_write(w[7:5], rs >> w[3:0]);
               OP_ST:    model_mem[ea[8:1]] = rt;
               OP_LD:    record_write(w[7:5], model_mem[ea[8:1]]);
               OP_STU: begin
                  model_mem[ea[8:1]] = rt;
                  record_write(w[10:8], ea);
               end
               OP_BTR:   record_write(w[4:2], bit_rev(rs));
               OP_ALU_ARITH: begin
                  case (w[1:0])
                     2'd0:    r = rs + rt;
                     2'd1:    r = rt - rs;
                     2'd2:    r = rs ^ rt;
                     default: r = rs & ~rt;
                  endcase
                  record_write(w[4:2], r);
               end
               OP_ALU_SHIFT: begin
                  case (w[1:0])
                     2'd0:    r = rot_left(rs, rt[3:0]);
                     2'd1:    r = rs << rt[3:0];
                     2'd2:    r = rot_right(rs, rt[3:0]);
                     default: r = rs >> rt[3:0];
                  endcase
                  record_write(w[4:2], r);
               end
               OP_SEQ:  record_write(w[4:2], word_t'(rs == rt));
               OP_SLT:  record_write(w[4:2], word_t'($signed(rs) < $signed(rt)));
               OP_SLE:  record_write(w[4:2], word_t'($signed(rs) <= $signed(rt)));
               OP_SCO:  record_write(w[4:2], word_t'((int'(rs) + int'(rt)) > 65535));
               OP_BEQZ: nxt = (rs == '0) ? pc + 16'd2 + s8 : nxt;
               OP_BNEZ: nxt = (rs != '0) ? pc + 16'd2 + s8 : nxt;
               OP_BLTZ: nxt = rs[15] ? pc + 16'd2 + s8 : nxt;
               OP_BGEZ: nxt = !rs[15] ? pc + 16'd2 + s8 : nxt;
               OP_LBI:  record_write(w[10:8], s8);
               OP_SLBI: record_write(w[10:8], (rs << 8) | {8'h00, w[7:0]});
               OP_J:    nxt = pc + 16'd2 + s11;
               OP_JAL: begin
                  record_write(3'd7, pc + 16'd2);
                  nxt = pc + 16'd2 + s11;
               end
               OP_JR:   nxt = rs + s8;
               OP_JALR: begin
                  record_write(3'd7, pc + 16'd2);       // Target uses Rs read before the link
                  nxt = rs + s8;
               end
               default: begin
                  // NOP, SIIC and opcode 00011
               end
            endcase
            pc = nxt;
         end
         steps++;
         if (steps > TIMEOUT_CYCLES)
            abort_run("reference model did not reach a halt");
      end
   endtask

   task automatic load_prog();
      int i;
      @(posedge clk);
      rst <= 1'b1;
      for (i = 0; i < prog.size(); i++) begin
         @(posedge clk);
         prog_we   <= 1'b1;
         prog_addr <= i[7:0];
         prog_data <= prog[i];
      end
      @(posedge clk);
      prog_we <= 1'b0;
      repeat (5) @(posedge clk);                      // Reset held for 5 cycles
   endtask

   task automatic run_prog(input string name);
      logic      exp_err;
      logic      done;
      wb_entry_t exp;
      int        cycles;
      exp_q.delete();
      predict(exp_err);
      load_prog();
      rst    <= 1'b0;
      cycles = 0;
      done   = 1'b0;
      while (!done) begin
         @(negedge clk);                              // Trace is stable mid-cycle
         if (wb_en) begin
            assert (exp_q.size() > 0)
               else report_mismatch($sformatf("%s: unexpected write to r%0d", name, wb_reg));
            exp = exp_q.pop_front();
            assert (wb_reg == exp.idx && wb_data == exp.data)
               else report_mismatch($sformatf("%s: write r%0d=%h, expected r%0d=%h",
                                              name, wb_reg, wb_data, exp.idx, exp.data));
         end
         if (halted) begin
            done = 1'b1;
         end else begin
            cycles++;
            if (cycles >= TIMEOUT_CYCLES)
               abort_run($sformatf("%s: core did not halt in time", name));
         end
      end
      assert (exp_q.size() == 0)
         else report_mismatch($sformatf("%s: %0d writes missing", name, exp_q.size()));
      assert (err == exp_err)
         else report_mismatch($sformatf("%s: err=%b, expected %b", name, err, exp_err));
      repeat (POST_HALT_CYCLES) begin
         @(negedge clk);
         assert (halted && !wb_en)
            else report_mismatch($sformatf("%s: core active after halt", name));
      end
      $display("Program %s checked", name);
   endtask

   task automatic test_immediates();
      repeat (3) begin
         prog.delete();
         load_const(3'd1, word_t'($urandom));
         load_const(3'd2, word_t'($urandom));
         prog.push_back(enc_imm5(OP_ADDI, 3'd1, 3'd3, 5'($urandom)));
         prog.push_back(enc_imm5(OP_SUBI, 3'd1, 3'd4, 5'($urandom)));
         prog.push_back(enc_imm5(OP_XORI, 3'd2, 3'd5, 5'($urandom)));
         prog.push_back(enc_imm5(OP_ANDNI, 3'd2, 3'd6, 5'($urandom)));
         prog.push_back(enc_imm5(OP_ROLI, 3'd1, 3'd3, 5'($urandom)));
         prog.push_back(enc_imm5(OP_SLLI, 3'd2, 3'd4, 5'($urandom)));
         prog.push_back(enc_imm5(OP_RORI, 3'd1, 3'd5, 5'($urandom)));
         prog.push_back(enc_imm5(OP_SRLI, 3'd2, 3'd6, 5'($urandom)));
         prog.push_back(enc_imm8(OP_LBI, 3'd7, 8'($urandom) | 8'h80));   // Negative byte
         prog.push_back(enc_imm11(OP_HALT, 11'd0));
         run_prog("immediates");
      end
   endtask

   task automatic test_reg_ops();
      repeat (3) begin
         prog.delete();
         load_const(3'd1, word_t'($urandom));
         load_const(3'd2, word_t'($urandom));
         prog.push_back(enc_reg(OP_ALU_ARITH, 3'd1, 3'd2, 3'd3, 2'd0));
         prog.push_back(enc_reg(OP_ALU_ARITH, 3'd1, 3'd2, 3'd4, 2'd1));
         prog.push_back(enc_reg(OP_ALU_ARITH, 3'd1, 3'd2, 3'd5, 2'd2));
         prog.push_back(enc_reg(OP_ALU_ARITH, 3'd1, 3'd2, 3'd6, 2'd3));
         prog.push_back(enc_reg(OP_ALU_SHIFT, 3'd1, 3'd2, 3'd3, 2'd0));
         prog.push_back(enc_reg(OP_ALU_SHIFT, 3'd1, 3'd2, 3'd4, 2'd1));
         prog.push_back(enc_reg(OP_ALU_SHIFT, 3'd1, 3'd2, 3'd5, 2'd2));
         prog.push_back(enc_reg(OP_ALU_SHIFT, 3'd1, 3'd2, 3'd6, 2'd3));
         prog.push_back(enc_reg(OP_BTR, 3'd1, 3'd0, 3'd7, 2'd0));
         prog.push_back(enc_reg(OP_SEQ, 3'd1, 3'd2, 3'd3, 2'd0));
         prog.push_back(enc_reg(OP_SEQ, 3'd1, 3'd1, 3'd4, 2'd0));
         prog.push_back(enc_reg(OP_SLT, 3'd1, 3'd2, 3'd5, 2'd0));
         prog.push_back(enc_reg(OP_SLT, 3'd2, 3'd1, 3'd6, 2'd0));
         prog.push_back(enc_reg(OP_SLE, 3'd1, 3'd1, 3'd3, 2'd0));
         prog.push_back(enc_reg(OP_SLE, 3'd2, 3'd1, 3'd4, 2'd0));
         prog.push_back(enc_reg(OP_SCO, 3'd1, 3'd2, 3'd5, 2'd0));
         prog.push_back(enc_imm11(OP_HALT, 11'd0));
         run_prog("register_ops");
      end
   endtask

   task automatic test_memory();
      logic [4:0] off;
      repeat (2) begin
         off = {1'b0, 3'($urandom), 1'b0};            // Small even offset
         prog.delete();
         prog.push_back(enc_imm8(OP_LBI, 3'd1, 8'($urandom) & 8'h7e));
         load_const(3'd2, word_t'($urandom));
         prog.push_back(enc_imm5(OP_ST, 3'd1, 3'd2, off));
         prog.push_back(enc_imm5(OP_LD, 3'd1, 3'd3, off));
         load_const(3'd4, word_t'($urandom));
         prog.push_back(enc_imm5(OP_STU, 3'd1, 3'd4, 5'h1e));   // Base moves down by 2
         prog.push_back(enc_imm5(OP_LD, 3'd1, 3'd5, 5'd0));
         prog.push_back(enc_imm11(OP_HALT, 11'd0));
         run_prog("memory");
      end
   endtask

   task automatic branch_over(input opcode_e op, input reg_idx_t r);
      prog.push_back(enc_imm8(op, r, 8'd2));
      prog.push_back(enc_imm8(OP_LBI, 3'd5, 8'(prog.size())));    // Marker runs only if not taken
   endtask

   task automatic test_control_flow();
      int i;
      prog.delete();
      load_const(3'd2, word_t'($urandom) | 16'h8000);
      load_const(3'd3, (word_t'($urandom) & 16'h7fff) | 16'h0001);
      branch_over(OP_BEQZ, 3'd1);
      branch_over(OP_BEQZ, 3'd3);
      branch_over(OP_BNEZ, 3'd3);
      branch_over(OP_BNEZ, 3'd1);
      branch_over(OP_BLTZ, 3'd2);
      branch_over(OP_BLTZ, 3'd3);
      branch_over(OP_BGEZ, 3'd3);
      branch_over(OP_BGEZ, 3'd2);
      prog.push_back(enc_imm11(OP_J, 11'd2));
      prog.push_back(enc_imm8(OP_LBI, 3'd5, 8'h77));
      prog.push_back(enc_imm11(OP_JAL, 11'd2));
      prog.push_back(enc_imm8(OP_LBI, 3'd5, 8'h78));
      i = prog.size();
      prog.push_back(enc_imm8(OP_LBI, 3'd4, 8'(2 * i + 4)));   // JR lands at word i+3
      prog.push_back(enc_imm8(OP_JR, 3'd4, 8'd2));
      prog.push_back(enc_imm8(OP_LBI, 3'd5, 8'h79));
      i = prog.size();
      prog.push_back(enc_imm8(OP_LBI, 3'd6, 8'(2 * i + 2)));
      prog.push_back(enc_imm8(OP_JALR, 3'd6, 8'd4));
      prog.push_back(enc_imm8(OP_LBI, 3'd5, 8'h7a));
      prog.push_back(enc_imm8(OP_LBI, 3'd1, 8'd3));            // Countdown loop
      prog.push_back(enc_imm5(OP_ADDI, 3'd1, 3'd1, 5'h1f));
      prog.push_back(enc_imm8(OP_BNEZ, 3'd1, 8'hfc));
      prog.push_back(enc_imm11(OP_HALT, 11'd0));
      run_prog("control_flow");
   endtask

   task automatic test_halt_and_illegal();
      prog.delete();
      prog.push_back(enc_imm11(OP_NOP, 11'($urandom)));
      prog.push_back(enc_imm11(OP_SIIC, 11'($urandom)));
      prog.push_back(enc_imm11(OP_NOP2, 11'($urandom)));
      prog.push_back(enc_imm8(OP_LBI, 3'd1, 8'h5a));
      prog.push_back(enc_imm11(OP_HALT, 11'($urandom)));
      prog.push_back(enc_imm8(OP_LBI, 3'd2, 8'h11));           // Never reached
      run_prog("halt_nop");
      prog.delete();
      prog.push_back(enc_imm8(OP_LBI, 3'd2, 8'h07));
      prog.push_back({5'bxxxxx, 11'd0});                       // Undefined opcode bits
      prog.push_back(enc_imm8(OP_LBI, 3'd3, 8'h22));
      run_prog("illegal");
   endtask

   initial begin
      int seed;
      seed = 32'hd331_f9d9;
      void'($urandom(seed));
      clk       = 1'b0;
      rst       = 1'b1;
      prog_we   = 1'b0;
      prog_addr = '0;
      prog_data = '0;
      repeat (5) @(posedge clk);
      test_immediates();
      test_reg_ops();
      test_memory();
      test_control_flow();
      test_halt_and_illegal();
      $display("Simulation passed");
      $finish;
   end

endmodule

/* src.f */
wisc_pkg.sv
control.sv
reg_file.sv
alu.sv
pc_unit.sv
instr_mem.sv
data_mem.sv
cpu_top.sv
tb_cpu.sv

/* Bender.yml */
package:
  name: wisc_cpu

sources:
  - files:
      - wisc_pkg.sv
      - control.sv
      - reg_file.sv
      - alu.sv
      - pc_unit.sv
      - instr_mem.sv
      - data_mem.sv
      - cpu_top.sv
  - target: test
    files:
      - tb_cpu.sv
